//--- Makefile
VERILATOR ?= verilator
TOP       ?= alu_tb
FLIST     ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FLIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES) verilog/alu_consts.svh
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim.f
+incdir+verilog
verilog/alu_pkg.sv
verilog/alu_arith.sv
verilog/alu_shift.sv
verilog/alu_flags.sv
verilog/alu_ctrl.sv
verilog/alu_top.sv
sim/alu_checks.sv
sim/alu_tb.sv

//--- sim/alu_checks.sv
// ALU checker with a reference model of results, flags and timing plus concurrent assertions
`timescale 1ns/100ps
`include "alu_consts.svh"

module alu_checks (
    input logic                clk,
    input logic                rst,
    input logic                start,
    input alu_pkg::alu_op_t    op,
    input alu_pkg::alu_width_t width,
    input logic [`ALU_DW-1:0]  op0,
    input logic [`ALU_DW-1:0]  op1,
    input logic [`ALU_DW-1:0]  imm,
    input logic [`ALU_DW-1:0]  dout,
    input logic [7:0]          flags,
    input logic                busy,
    input logic                done
);

int                 err_cnt = 0;
logic [7:0]         mf, mfd;         // model F and F'
logic [`ALU_DW-1:0] exp_dout;
int                 cnt_q;           // edges left until the result lands
logic               exp_done_q, busy_exp_q;

always @(posedge clk or posedge rst) begin : model
    logic [31:0] mask, a, b, r, rr;
    logic [63:0] full;
    logic [7:0]  nf;
    logic        c, nc, sub;
    int          wb, n, k;
    if (rst) begin
        mf         <= '0;
        mfd        <= '0;
        exp_dout   <= '0;
        cnt_q      <= 0;
        exp_done_q <= 1'b0;
        busy_exp_q <= 1'b0;
    end else if (start) begin
        wb   = (width == alu_pkg::width_byte) ? 8 : (width == alu_pkg::width_word) ? 16 : 32;
        mask = (wb == 32) ? 32'hffff_ffff : (32'd1 << wb) - 32'd1;
        a    = op0 & mask;
        b    = imm & mask;
        nf   = mf;
        r    = exp_dout;
        n    = 1;
        case (op)
            alu_pkg::op_move: r = op1 & mask;
            alu_pkg::op_add, alu_pkg::op_adc, alu_pkg::op_sub,
            alu_pkg::op_sbc, alu_pkg::op_cp: begin
                sub = op inside {alu_pkg::op_sub, alu_pkg::op_sbc, alu_pkg::op_cp};
                c   = (op == alu_pkg::op_adc || op == alu_pkg::op_sbc) ? mf[`FLAG_C] : 1'b0;
                if (sub)
                    full = {32'd0, a} - {32'd0, b} - {63'd0, c};
                else
                    full = {32'd0, a} + {32'd0, b} + {63'd0, c};
                rr = full[31:0] & mask;
                nf = '0;
                nf[`FLAG_S] = rr[wb-1];
                nf[`FLAG_Z] = (rr == 32'd0);
                if (sub)
                    nf[`FLAG_H] = (a & 32'hf) < (b & 32'hf) + {31'd0, c};
                else
                    nf[`FLAG_H] = (a & 32'hf) + (b & 32'hf) + {31'd0, c} > 32'hf;
                if (sub)   // overflow when signs differ and result sign leaves a
                    nf[`FLAG_V] = (a[wb-1] != b[wb-1]) && (rr[wb-1] != a[wb-1]);
                else
                    nf[`FLAG_V] = (a[wb-1] == b[wb-1]) && (rr[wb-1] != a[wb-1]);
                nf[`FLAG_N] = sub;
                nf[`FLAG_C] = full[wb];      // borrow shows as a wrapped top bit
                if (op != alu_pkg::op_cp)
                    r = rr;
            end
            alu_pkg::op_and, alu_pkg::op_or, alu_pkg::op_xor: begin
                if (op == alu_pkg::op_and)
                    rr = a & b;
                else if (op == alu_pkg::op_or)
                    rr = a | b;
                else
                    rr = a ^ b;
                nf = '0;
                nf[`FLAG_S] = rr[wb-1];
                nf[`FLAG_Z] = (rr == 32'd0);
                nf[`FLAG_H] = (op == alu_pkg::op_and);
                nf[`FLAG_V] = (wb == 8) ? ~^rr[7:0] : ~^rr[15:0];
                r = rr;
            end
            alu_pkg::op_scf: begin
                nf[`FLAG_C] = 1'b1;
                nf[`FLAG_H] = 1'b0;
                nf[`FLAG_N] = 1'b0;
            end
            alu_pkg::op_rcf: begin
                nf[`FLAG_C] = 1'b0;
                nf[`FLAG_H] = 1'b0;
                nf[`FLAG_N] = 1'b0;
            end
            alu_pkg::op_ccf: begin
                nf[`FLAG_C] = ~mf[`FLAG_C];
                nf[`FLAG_N] = 1'b0;
            end
            alu_pkg::op_exff: begin
                nf = mfd;
                mfd <= mf;
            end
            alu_pkg::op_popf: nf = imm[7:0] & 8'hd7;   // pads 5 and 3 forced low
            default: begin
                // shifts and rotates one bit at a time
                n = (imm[3:0] == 4'd0) ? 16 : int'(imm[3:0]);
                r = a;
                c = mf[`FLAG_C];
                for (k = 0; k < n; k++) begin
                    case (op)
                        alu_pkg::op_rl: begin
                            nc = r[wb-1];
                            r  = (r << 1) | {31'd0, c};
                        end
                        alu_pkg::op_rlc: begin
                            nc = r[wb-1];
                            r  = (r << 1) | {31'd0, nc};
                        end
                        alu_pkg::op_sla, alu_pkg::op_sll: begin
                            nc = r[wb-1];
                            r  = r << 1;
                        end
                        alu_pkg::op_rr: begin
                            nc = r[0];
                            r  = (r >> 1) | ({31'd0, c} << (wb - 1));
                        end
                        alu_pkg::op_rrc: begin
                            nc = r[0];
                            r  = (r >> 1) | ({31'd0, nc} << (wb - 1));
                        end
                        alu_pkg::op_sra: begin
                            nc = r[0];
                            r  = (r >> 1) | ({31'd0, r[wb-1]} << (wb - 1));
                        end
                        default: begin
                            nc = r[0];
                            r  = r >> 1;
                        end
                    endcase
                    r = r & mask;
                    c = nc;
                end
                nf[`FLAG_S] = r[wb-1];
                nf[`FLAG_Z] = (r == 32'd0);
                nf[`FLAG_H] = 1'b0;
                nf[`FLAG_V] = ~^r[15:0];
                nf[`FLAG_N] = 1'b0;
                nf[`FLAG_C] = c;
            end
        endcase
        mf         <= nf;
        exp_dout   <= r;
        cnt_q      <= n - 1;
        exp_done_q <= (n == 1);
        busy_exp_q <= (n > 1);
    end else if (cnt_q != 0) begin
        cnt_q      <= cnt_q - 1;
        exp_done_q <= (cnt_q == 1);
        busy_exp_q <= (cnt_q >= 2);
    end else begin
        exp_done_q <= 1'b0;
        busy_exp_q <= 1'b0;
    end
end

a_reset_state: assert property (@(posedge clk) $fell(rst) |->
        dout == '0 && flags == 8'h00 && !busy && !done)
    else begin
        $display("reset state wrong: outputs not cleared after reset");
        err_cnt++;
    end
a_done_time: assert property (@(posedge clk) disable iff (rst) done == exp_done_q)
    else begin
        $display("Error: done = %h, expected %h", $sampled(done), $sampled(exp_done_q));
        err_cnt++;
    end
a_busy_time: assert property (@(posedge clk) disable iff (rst) busy == busy_exp_q)
    else begin
        $display("Error: busy = %h, expected %h", $sampled(busy), $sampled(busy_exp_q));
        err_cnt++;
    end
a_dout: assert property (@(posedge clk) disable iff (rst) done |-> dout == exp_dout)
    else begin
        $display("Error: dout = %h, expected %h", $sampled(dout), $sampled(exp_dout));
        err_cnt++;
    end
a_flags: assert property (@(posedge clk) disable iff (rst) done |-> flags == mf)
    else begin
        $display("Error: flags = %h, expected %h", $sampled(flags), $sampled(mf));
        err_cnt++;
    end
a_pads: assert property (@(posedge clk) disable iff (rst)
        flags[5] == 1'b0 && flags[3] == 1'b0)
    else begin
        $display("Error: flags = %h, pad bits not zero", $sampled(flags));
        err_cnt++;
    end
a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
        $display("done stayed high for two cycles");
        err_cnt++;
    end
a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
    else begin
        $display("start issued while the shifter was busy");
        err_cnt++;
    end

endmodule

//--- sim/alu_tb.sv
// ALU testbench with clock, reset, operation stimulus, watchdog and result summary
`timescale 1ns/100ps
`include "alu_consts.svh"

module alu_tb;

localparam int op_total = 425;       // operations issued over all tests

logic                clk, rst, start, busy, done;
alu_pkg::alu_op_t    op;
alu_pkg::alu_width_t width;
logic [`ALU_DW-1:0]  op0, op1, imm, dout;
alu_pkg::flag_word_t flags;
int                  seed = 78507;
int                  ops = 0;

alu_pkg::alu_width_t widths[3] = '{alu_pkg::width_byte, alu_pkg::width_word,
                                   alu_pkg::width_long};
alu_pkg::alu_op_t arith_ops[5] = '{alu_pkg::op_add, alu_pkg::op_adc, alu_pkg::op_sub,
                                   alu_pkg::op_sbc, alu_pkg::op_cp};
alu_pkg::alu_op_t logic_ops[3] = '{alu_pkg::op_and, alu_pkg::op_or, alu_pkg::op_xor};
alu_pkg::alu_op_t shift_ops[8] = '{alu_pkg::op_rl, alu_pkg::op_rr, alu_pkg::op_rlc,
                                   alu_pkg::op_rrc, alu_pkg::op_sla, alu_pkg::op_sra,
                                   alu_pkg::op_sll, alu_pkg::op_srl};
logic [31:0] bnd_a[3] = '{32'h0000_007f, 32'h0000_00ff, 32'h0000_0000};

alu_top i_alu_top (
    .clk(clk), .rst(rst), .start(start), .op(op), .width(width),
    .op0(op0), .op1(op1), .imm(imm),
    .dout(dout), .flags(flags), .busy(busy), .done(done)
);

alu_checks i_checks (
    .clk(clk), .rst(rst), .start(start), .op(op), .width(width),
    .op0(op0), .op1(op1), .imm(imm),
    .dout(dout), .flags(flags.bits), .busy(busy), .done(done)
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

// one operation from the falling edge through done and one idle cycle
task automatic issue(input alu_pkg::alu_op_t o, input alu_pkg::alu_width_t w,
                     input logic [31:0] a, input logic [31:0] src,
                     input logic [31:0] b);
    start = 1'b1;
    op    = o;
    width = w;
    op0   = a;
    op1   = src;
    imm   = b;
    @(negedge clk);
    start = 1'b0;
    while (!done) @(negedge clk);
    @(negedge clk);    // gap cycle so done pulses never touch
    ops++;
endtask

task automatic report(input string name);
    $display("test %s finished: %0d ops so far, %0d errors so far",
             name, ops, i_checks.err_cnt);
endtask

initial begin
    start = 1'b0;
    op    = alu_pkg::op_move;
    width = alu_pkg::width_byte;
    op0   = '0;
    op1   = '0;
    imm   = '0;
    rst   = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    report("reset");

    foreach (arith_ops[i]) begin
        foreach (widths[j]) begin
            for (int k = 0; k < 4; k++)
                issue(arith_ops[i], widths[j], $random(seed), 0, $random(seed));
            foreach (bnd_a[k])
                issue(arith_ops[i], widths[j], bnd_a[k], 0, 32'd1);
        end
    end
    report("add/sub");

    foreach (logic_ops[i])
        foreach (widths[j])
            for (int k = 0; k < 4; k++)
                issue(logic_ops[i], widths[j], $random(seed), 0, $random(seed));
    report("logic");

    foreach (shift_ops[i]) begin
        for (int cnt = 0; cnt <= 16; cnt++) begin
            issue(alu_pkg::op_popf, alu_pkg::width_byte, 0, 0, $random(seed));  // random carry
            issue(shift_ops[i], widths[cnt % 3], $random(seed), 0,
                  {28'($random(seed)), 4'(cnt)});
        end
    end
    report("shift");

    issue(alu_pkg::op_popf, alu_pkg::width_byte, 0, 0, $random(seed));
    issue(alu_pkg::op_scf, alu_pkg::width_byte, 0, 0, 0);
    issue(alu_pkg::op_rcf, alu_pkg::width_byte, 0, 0, 0);
    issue(alu_pkg::op_ccf, alu_pkg::width_byte, 0, 0, 0);
    issue(alu_pkg::op_ccf, alu_pkg::width_byte, 0, 0, 0);
    issue(alu_pkg::op_popf, alu_pkg::width_byte, 0, 0, 32'hff);
    issue(alu_pkg::op_exff, alu_pkg::width_byte, 0, 0, 0);
    issue(alu_pkg::op_popf, alu_pkg::width_byte, 0, 0, $random(seed));
    issue(alu_pkg::op_exff, alu_pkg::width_byte, 0, 0, 0);
    issue(alu_pkg::op_exff, alu_pkg::width_byte, 0, 0, 0);   // back to the original pair
    issue(alu_pkg::op_move, alu_pkg::width_word, 0, $random(seed), 0);
    issue(alu_pkg::op_move, alu_pkg::width_long, 0, $random(seed), 0);
    report("flag ops");

    repeat (2) @(negedge clk);
    $display("ops %0d, errors %0d", ops, i_checks.err_cnt);
    if (i_checks.err_cnt == 0 && ops == op_total) begin
        $display("TB PASSED");
    end else begin
        if (ops != op_total)
            $display("operation count %0d does not match %0d", ops, op_total);
        $display("TB FAILED");
    end
    $finish;
end

initial begin
    #((op_total + 10) * 20 * 20);
    $display("watchdog expired after %0d ops", ops);
    $display("TB FAILED");
    $finish;
end

endmodule

//--- verilog/alu_arith.sv
// ALU arithmetic and logic unit: add/sub/compare and AND/OR/XOR with flag candidates
`timescale 1ns/100ps
`include "alu_consts.svh"

module alu_arith (
    input  alu_pkg::alu_op_t    op,
    input  alu_pkg::alu_width_t width,
    input  logic [`ALU_DW-1:0]  opa,
    input  logic [`ALU_DW-1:0]  opb,
    input  logic                carry_in,
    output logic [`ALU_DW-1:0]  rslt,
    output alu_pkg::flag_word_t cand
);

logic [4:0]         msb;
logic [`ALU_DW-1:0] mask, bx, sum, raw, res;
logic [`ALU_DW:0]   sx;
logic               sub, ci, c3, c7, c15, c31, cy;

// sign extend the selected width to 33 bits
function automatic logic [`ALU_DW:0] sext(
    input logic [`ALU_DW-1:0] x,
    input logic [4:0]         m,
    input logic [`ALU_DW-1:0] msk
);
    sext = {x[m], (x & msk) | ({`ALU_DW{x[m]}} & ~msk)};
endfunction

always_comb begin
    case (width)
        alu_pkg::width_byte: begin
            msb  = 5'd7;
            mask = 32'h0000_00ff;
        end
        alu_pkg::width_word: begin
            msb  = 5'd15;
            mask = 32'h0000_ffff;
        end
        default: begin
            msb  = 5'd31;
            mask = 32'hffff_ffff;
        end
    endcase
end

// subtract as a + ~b + ~borrow, carries inverted back into borrows
assign sub = op inside {alu_pkg::op_sub, alu_pkg::op_sbc, alu_pkg::op_cp};
assign ci  = ((op == alu_pkg::op_adc || op == alu_pkg::op_sbc) && carry_in) ^ sub;
assign bx  = sub ? ~opb : opb;

assign {c3,  sum[3:0]}   = {1'b0, opa[3:0]}   + {1'b0, bx[3:0]}   + {4'd0, ci};
assign {c7,  sum[7:4]}   = {1'b0, opa[7:4]}   + {1'b0, bx[7:4]}   + {4'd0, c3};
assign {c15, sum[15:8]}  = {1'b0, opa[15:8]}  + {1'b0, bx[15:8]}  + {8'd0, c7};
assign {c31, sum[31:16]} = {1'b0, opa[31:16]} + {1'b0, bx[31:16]} + {16'd0, c15};

assign sx = sext(opa, msb, mask) + sext(bx, msb, mask) + {{`ALU_DW{1'b0}}, ci};
assign cy = (width == alu_pkg::width_byte) ? c7 :
            (width == alu_pkg::width_word) ? c15 : c31;

always_comb begin
    case (op)
        alu_pkg::op_and: raw = opa & opb;
        alu_pkg::op_or:  raw = opa | opb;
        alu_pkg::op_xor: raw = opa ^ opb;
        alu_pkg::op_move: raw = opb;
        default:         raw = sum;
    endcase
end

assign res  = raw & mask;    // upper bits cleared at narrow widths
assign rslt = res;

always_comb begin
    cand     = '0;
    cand.f.s = res[msb];
    cand.f.z = (res == '0);
    if (op inside {alu_pkg::op_and, alu_pkg::op_or, alu_pkg::op_xor}) begin
        cand.f.h = (op == alu_pkg::op_and);
        cand.f.v = (width == alu_pkg::width_byte) ? ~^res[7:0] : ~^res[15:0];
    end else begin
        cand.f.h = c3 ^ sub;         // nibble borrow on subtract
        cand.f.v = sx[`ALU_DW] ^ sx[msb];
        cand.f.n = sub;
        cand.f.c = cy ^ sub;
    end
end

endmodule

//--- verilog/alu_consts.svh
// ALU constants: data and control widths, operation codes, flag bit positions
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

`define ALU_DW      32
`define ALU_OPW     5
`define SHIFT_CNT_W 5

// flag byte layout, bits 5 and 3 read as zero
`define FLAG_S 7
`define FLAG_Z 6
`define FLAG_H 4
`define FLAG_V 2
`define FLAG_N 1
`define FLAG_C 0

`define ALU_OP_MOVE 5'd0
`define ALU_OP_ADD  5'd1
`define ALU_OP_ADC  5'd2
`define ALU_OP_SUB  5'd3
`define ALU_OP_SBC  5'd4
`define ALU_OP_CP   5'd5
`define ALU_OP_AND  5'd6
`define ALU_OP_OR   5'd7
`define ALU_OP_XOR  5'd8
`define ALU_OP_RL   5'd9
`define ALU_OP_RR   5'd10
`define ALU_OP_RLC  5'd11
`define ALU_OP_RRC  5'd12
`define ALU_OP_SLA  5'd13
`define ALU_OP_SRA  5'd14
`define ALU_OP_SLL  5'd15
`define ALU_OP_SRL  5'd16
`define ALU_OP_SCF  5'd17
`define ALU_OP_RCF  5'd18
`define ALU_OP_CCF  5'd19
`define ALU_OP_EXFF 5'd20
`define ALU_OP_POPF 5'd21

`endif

//--- verilog/alu_ctrl.sv
// ALU control: operation issue, operand hold, result register and done strobe
`timescale 1ns/100ps
`include "alu_consts.svh"

module alu_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  alu_pkg::alu_op_t    op,
    input  alu_pkg::alu_width_t width,
    input  logic [`ALU_DW-1:0]  op0,
    input  logic [`ALU_DW-1:0]  op1,
    input  logic [`ALU_DW-1:0]  imm,
    input  logic [`ALU_DW-1:0]  arith_rslt,
    input  logic [`ALU_DW-1:0]  shift_rslt,
    input  logic                shift_last,
    input  logic                busy,
    output alu_pkg::alu_op_t    op_q,
    output alu_pkg::alu_width_t width_q,
    output logic [`ALU_DW-1:0]  opa_q,
    output logic [`ALU_DW-1:0]  opb_q,
    output logic                shift_go,
    output logic                flag_we,
    output logic [`ALU_DW-1:0]  dout,
    output logic                done
);

alu_pkg::alu_op_t    op_r;
alu_pkg::alu_width_t width_r;
logic [`ALU_DW-1:0]  opa_r, opb_r, src;
logic                is_shift, writes;

// register moves take op1, every other operation reads the immediate
assign src      = (op == alu_pkg::op_move) ? op1 : imm;
assign is_shift = op inside {alu_pkg::op_rl, alu_pkg::op_rr, alu_pkg::op_rlc,
                             alu_pkg::op_rrc, alu_pkg::op_sla, alu_pkg::op_sra,
                             alu_pkg::op_sll, alu_pkg::op_srl};
assign writes   = op inside {alu_pkg::op_move, alu_pkg::op_add, alu_pkg::op_adc,
                             alu_pkg::op_sub, alu_pkg::op_sbc, alu_pkg::op_and,
                             alu_pkg::op_or, alu_pkg::op_xor};

// live inputs on the start cycle, held copies while a shift runs
assign op_q    = start ? op : op_r;
assign width_q = start ? width : width_r;
assign opa_q   = start ? op0 : opa_r;
assign opb_q   = start ? src : opb_r;

assign shift_go = start && is_shift;
assign flag_we  = start && !is_shift && op != alu_pkg::op_move;

always_ff @(posedge clk) begin
    if (start) begin
        op_r    <= op;
        width_r <= width;
        opa_r   <= op0;
        opb_r   <= src;
    end
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        dout <= '0;
        done <= 1'b0;
    end else begin
        done <= (start && !is_shift) || shift_last;
        if (start && writes)
            dout <= arith_rslt;
        else if (shift_last)
            dout <= shift_rslt;   // also a 1-bit shift on its start cycle
    end
end

a_no_start_busy: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
    else $error("start while shifter busy");
a_done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("done high two cycles in a row");
a_busy_cause: assert property (@(posedge clk) disable iff (rst) $rose(busy) |-> $past(shift_go))
    else $error("busy rose without a shift issue");

endmodule

//--- verilog/alu_flags.sv
// ALU flag register F with shadow F', carry operations and flag load
`timescale 1ns/100ps
`include "alu_consts.svh"

module alu_flags (
    input  logic                clk,
    input  logic                rst,
    input  logic                we,
    input  alu_pkg::alu_op_t    op,
    input  alu_pkg::flag_word_t cand,
    input  logic                shift_c,
    input  logic                shift_last,
    input  logic [1:0]          res_sz,
    input  logic [`ALU_DW-1:0]  shift_rslt,
    input  logic [7:0]          imm_byte,
    output alu_pkg::flag_word_t flags,
    output logic                carry
);

alu_pkg::flag_word_t f_q, fd_q, f_nxt, fd_nxt;

always_comb begin
    f_nxt  = f_q;
    fd_nxt = fd_q;
    if (we) begin
        case (op)
            alu_pkg::op_scf: begin
                f_nxt.f.c = 1'b1;
                f_nxt.f.h = 1'b0;
                f_nxt.f.n = 1'b0;
            end
            alu_pkg::op_rcf: begin
                f_nxt.f.c = 1'b0;
                f_nxt.f.h = 1'b0;
                f_nxt.f.n = 1'b0;
            end
            alu_pkg::op_ccf: begin
                f_nxt.f.c = ~f_q.f.c;
                f_nxt.f.n = 1'b0;
            end
            alu_pkg::op_exff: begin
                f_nxt  = fd_q;
                fd_nxt = f_q;
            end
            alu_pkg::op_popf: begin
                f_nxt.bits   = imm_byte;
                f_nxt.f.pad5 = 1'b0;
                f_nxt.f.pad3 = 1'b0;
            end
            default: f_nxt = cand;
        endcase
    end else if (shift_last) begin
        // narrow results are zero above the width, so 16-bit parity covers a byte too
        f_nxt.bits[`FLAG_S] = res_sz[1];
        f_nxt.bits[`FLAG_Z] = res_sz[0];
        f_nxt.bits[`FLAG_H] = 1'b0;
        f_nxt.bits[`FLAG_V] = ~^shift_rslt[15:0];
        f_nxt.bits[`FLAG_N] = 1'b0;
        f_nxt.bits[`FLAG_C] = shift_c;
    end
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        f_q  <= '0;
        fd_q <= '0;
    end else begin
        f_q  <= f_nxt;
        fd_q <= fd_nxt;
    end
end

assign flags = f_q;
assign carry = f_q.f.c;

endmodule

//--- verilog/alu_pkg.sv
// ALU types: operand width, operation select and the flag word
package alu_pkg;

`include "alu_consts.svh"

typedef enum logic [1:0] {
    width_byte = 2'd0,
    width_word = 2'd1,
    width_long = 2'd2
} alu_width_t;

typedef enum logic [`ALU_OPW-1:0] {
    op_move = `ALU_OP_MOVE,
    op_add  = `ALU_OP_ADD,
    op_adc  = `ALU_OP_ADC,
    op_sub  = `ALU_OP_SUB,
    op_sbc  = `ALU_OP_SBC,
    op_cp   = `ALU_OP_CP,   // flags only
    op_and  = `ALU_OP_AND,
    op_or   = `ALU_OP_OR,
    op_xor  = `ALU_OP_XOR,
    op_rl   = `ALU_OP_RL,   // through carry
    op_rr   = `ALU_OP_RR,
    op_rlc  = `ALU_OP_RLC,  // circular
    op_rrc  = `ALU_OP_RRC,
    op_sla  = `ALU_OP_SLA,
    op_sra  = `ALU_OP_SRA,
    op_sll  = `ALU_OP_SLL,
    op_srl  = `ALU_OP_SRL,
    op_scf  = `ALU_OP_SCF,
    op_rcf  = `ALU_OP_RCF,
    op_ccf  = `ALU_OP_CCF,
    op_exff = `ALU_OP_EXFF, // swap F and F'
    op_popf = `ALU_OP_POPF
} alu_op_t;

typedef struct packed {
    logic s;
    logic z;
    logic pad5;   // always zero
    logic h;
    logic pad3;   // always zero
    logic v;      // overflow or even parity
    logic n;
    logic c;
} flag_bits_t;

typedef union packed {
    logic [7:0] bits;
    flag_bits_t f;
} flag_word_t;

endpackage

//--- verilog/alu_shift.sv
// ALU shifter: iterative shift and rotate, one bit per cycle at the selected width
`timescale 1ns/100ps
`include "alu_consts.svh"

module alu_shift (
    input  logic                clk,
    input  logic                rst,
    input  logic                go,
    input  alu_pkg::alu_op_t    op,
    input  alu_pkg::alu_width_t width,
    input  logic [`ALU_DW-1:0]  opa,
    input  logic [3:0]          count_src,
    input  logic                carry_in,
    output logic [`ALU_DW-1:0]  rslt,
    output logic                c_out,
    output logic [1:0]          res_sz,   // sign, zero of rslt
    output logic                busy,
    output logic                last
);

logic [4:0]             msb;
logic [`ALU_DW-1:0]     mask, src, nxt, sh_q;
logic [`SHIFT_CNT_W-1:0] n, cnt;
logic                   cin, c_q, fill, left, nxt_c;

assign n = {count_src == 4'd0, count_src};   // zero means 16

always_comb begin
    case (width)
        alu_pkg::width_byte: begin
            msb  = 5'd7;
            mask = 32'h0000_00ff;
        end
        alu_pkg::width_word: begin
            msb  = 5'd15;
            mask = 32'h0000_ffff;
        end
        default: begin
            msb  = 5'd31;
            mask = 32'hffff_ffff;
        end
    endcase
end

// first step works on the live operand, later steps on the held value
assign src  = go ? (opa & mask) : sh_q;
assign cin  = go ? carry_in : c_q;
assign left = op inside {alu_pkg::op_rl, alu_pkg::op_rlc, alu_pkg::op_sla, alu_pkg::op_sll};

always_comb begin
    case (op)
        alu_pkg::op_rl,
        alu_pkg::op_rr:  fill = cin;
        alu_pkg::op_rlc,
        alu_pkg::op_sra: fill = src[msb];
        alu_pkg::op_rrc: fill = src[0];
        default:         fill = 1'b0;
    endcase
    if (left) begin
        nxt   = ((src << 1) | {{(`ALU_DW-1){1'b0}}, fill}) & mask;
        nxt_c = src[msb];
    end else begin
        nxt   = (src >> 1) | ({{(`ALU_DW-1){1'b0}}, fill} << msb);
        nxt_c = src[0];
    end
end

assign rslt   = nxt;
assign c_out  = nxt_c;
assign res_sz = {nxt[msb], nxt == '0};
assign last   = go ? (n == 5'd1) : (busy && cnt == 5'd1);

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        busy <= 1'b0;
        cnt  <= '0;
    end else if (go) begin
        busy <= (n != 5'd1);
        cnt  <= n - 5'd1;    // steps left after this one
    end else if (busy) begin
        busy <= (cnt != 5'd1);
        cnt  <= cnt - 5'd1;
    end
end

always_ff @(posedge clk) begin
    if (go || busy) begin
        sh_q <= nxt;
        c_q  <= nxt_c;
    end
end

a_cnt_live: assert property (@(posedge clk) disable iff (rst) busy |-> cnt != '0)
    else $error("shift count underflow while busy");

endmodule

//--- verilog/alu_top.sv
// ALU top level: connects control, arithmetic, shifter and flag units
`timescale 1ns/100ps
`include "alu_consts.svh"

module alu_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  alu_pkg::alu_op_t    op,
    input  alu_pkg::alu_width_t width,
    input  logic [`ALU_DW-1:0]  op0,
    input  logic [`ALU_DW-1:0]  op1,
    input  logic [`ALU_DW-1:0]  imm,
    output logic [`ALU_DW-1:0]  dout,
    output alu_pkg::flag_word_t flags,
    output logic                busy,
    output logic                done
);

alu_pkg::alu_op_t    op_q;
alu_pkg::alu_width_t width_q;
alu_pkg::flag_word_t cand;
logic [`ALU_DW-1:0]  opa_q, opb_q, arith_rslt, shift_rslt;
logic [1:0]          res_sz;
logic                shift_go, shift_last, shift_c, flag_we, carry;

alu_ctrl i_ctrl (
    .clk(clk), .rst(rst), .start(start), .op(op), .width(width),
    .op0(op0), .op1(op1), .imm(imm),
    .arith_rslt(arith_rslt), .shift_rslt(shift_rslt),
    .shift_last(shift_last), .busy(busy),
    .op_q(op_q), .width_q(width_q), .opa_q(opa_q), .opb_q(opb_q),
    .shift_go(shift_go), .flag_we(flag_we), .dout(dout), .done(done)
);

alu_arith i_arith (
    .op(op_q), .width(width_q), .opa(opa_q), .opb(opb_q),
    .carry_in(carry), .rslt(arith_rslt), .cand(cand)
);

alu_shift i_shift (
    .clk(clk), .rst(rst), .go(shift_go), .op(op_q), .width(width_q),
    .opa(opa_q), .count_src(opb_q[3:0]), .carry_in(carry),
    .rslt(shift_rslt), .c_out(shift_c), .res_sz(res_sz),
    .busy(busy), .last(shift_last)
);

alu_flags i_flags (
    .clk(clk), .rst(rst), .we(flag_we), .op(op_q), .cand(cand),
    .shift_c(shift_c), .shift_last(shift_last), .res_sz(res_sz),
    .shift_rslt(shift_rslt), .imm_byte(opb_q[7:0]),
    .flags(flags), .carry(carry)
);

endmodule
